// File: build.f
source/wsn_pkg.sv
source/pkt_apb_regs.sv
source/pkt_filter.sv
source/node_info.sv
source/known_ch.sv
source/q_table_update.sv
source/cluster_node_top.sv
verification/cluster_node_assertions.sv
verification/tb_cluster_node.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cluster node testbench with verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cluster_node -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_cluster_node > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

// File: source/cluster_node_top.sv
`timescale 1ns/10ps

module cluster_node_top #(
    parameter int NBR_DEPTH   = 8,
    parameter int MAX_CH_HOPS = 4
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [wsn_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic [wsn_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [wsn_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr
);

    logic [wsn_pkg::NODE_ID_W-1:0]  pkt_src;
    logic [wsn_pkg::NODE_ID_W-1:0]  pkt_dest;
    logic [wsn_pkg::NODE_ID_W-1:0]  pkt_value;
    wsn_pkg::pkt_type_e             pkt_type;
    logic                           new_pkt;
    logic                           my_id_wr;
    logic                           clr_recluster;
    logic [wsn_pkg::NODE_ID_W-1:0]  my_id_data;
    logic [wsn_pkg::NODE_ID_W-1:0]  my_id;
    logic                           en_mni;
    logic                           en_kch;
    logic                           en_qtu;
    logic                           i_am_dest;
    logic                           fwd;
    logic [wsn_pkg::NODE_ID_W-1:0]  hops_from_sink;
    logic                           role_ch;
    logic [7:0]                     timeslot;
    logic                           ch_valid;
    logic [wsn_pkg::NODE_ID_W-1:0]  ch_id;
    logic [7:0]                     ch_hops;
    logic [7:0]                     ch_q;
    logic                           recluster;
    logic [$clog2(NBR_DEPTH)-1:0]   nbr_index;
    logic [wsn_pkg::NODE_ID_W:0]    nbr_entry;
    logic [31:0]                    node_status;
    logic [31:0]                    ch_info;

    // status words as seen by the host
    assign node_status = {hops_from_sink, timeslot, 6'b0, recluster, role_ch};
    assign ch_info     = {ch_id[7:0], ch_q, ch_hops, 7'b0, ch_valid};

    pkt_apb_regs #(.NBR_DEPTH(NBR_DEPTH)) u_regs (
        .clk(clk), .nrst(nrst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pkt_src(pkt_src), .pkt_dest(pkt_dest), .pkt_value(pkt_value),
        .pkt_type(pkt_type),
        .new_pkt(new_pkt), .my_id_wr(my_id_wr), .clr_recluster(clr_recluster),
        .my_id_data(my_id_data),
        .fwd(fwd),
        .node_status(node_status), .ch_info(ch_info),
        .nbr_index(nbr_index), .nbr_entry(nbr_entry)
    );

    pkt_filter u_filter (
        .clk(clk), .nrst(nrst),
        .new_pkt(new_pkt), .pkt_type(pkt_type), .pkt_dest(pkt_dest),
        .my_id(my_id), .role_ch(role_ch),
        .en_mni(en_mni), .en_kch(en_kch), .en_qtu(en_qtu),
        .i_am_dest(i_am_dest), .fwd(fwd)
    );

    node_info u_node_info (
        .clk(clk), .nrst(nrst),
        .en_mni(en_mni), .i_am_dest(i_am_dest), .my_id_wr(my_id_wr),
        .my_id_data(my_id_data), .pkt_type(pkt_type),
        .pkt_src(pkt_src), .pkt_value(pkt_value),
        .my_id(my_id), .hops_from_sink(hops_from_sink),
        .role_ch(role_ch), .timeslot(timeslot)
    );

    known_ch #(.MAX_CH_HOPS(MAX_CH_HOPS)) u_known_ch (
        .clk(clk), .nrst(nrst),
        .en_kch(en_kch), .pkt_type(pkt_type),
        .pkt_src(pkt_src), .pkt_value(pkt_value), .my_id(my_id),
        .ch_valid(ch_valid), .ch_id(ch_id), .ch_hops(ch_hops), .ch_q(ch_q)
    );

    q_table_update #(.NBR_DEPTH(NBR_DEPTH)) u_qtu (
        .clk(clk), .nrst(nrst),
        .en_qtu(en_qtu), .pkt_type(pkt_type),
        .pkt_src(pkt_src), .pkt_dest(pkt_dest), .pkt_value(pkt_value),
        .ch_valid(ch_valid), .ch_id(ch_id),
        .clr_recluster(clr_recluster), .nbr_index(nbr_index),
        .nbr_entry(nbr_entry), .recluster(recluster)
    );

endmodule

// File: source/known_ch.sv
`timescale 1ns/10ps

module known_ch #(
    parameter int MAX_CH_HOPS = 4
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            en_kch,
    input  wsn_pkg::pkt_type_e              pkt_type,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_src,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_value,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   my_id,
    output logic                            ch_valid,
    output logic [wsn_pkg::NODE_ID_W-1:0]   ch_id,      // chosen cluster head
    output logic [7:0]                      ch_hops,
    output logic [7:0]                      ch_q
);

    logic [7:0] inv_hops;
    logic [7:0] inv_q;
    logic       accept;

    assign inv_hops = pkt_value[7:0];                   // invite payload split
    assign inv_q    = pkt_value[15:8];
    assign accept   = (int'(inv_hops) <= MAX_CH_HOPS) && (!ch_valid || (inv_q > ch_q));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            ch_valid <= 1'b0;
            ch_id    <= '0;
            ch_hops  <= '0;
            ch_q     <= '0;
        end else if (en_kch) begin
            case (pkt_type)
                wsn_pkg::PKT_CHE: begin
                    if (pkt_src != my_id)
                        ch_valid <= 1'b0;               // new election round
                end
                wsn_pkg::PKT_INVITE: begin
                    if (accept) begin                   // best q within reach wins
                        ch_valid <= 1'b1;
                        ch_id    <= pkt_src;
                        ch_hops  <= inv_hops;
                        ch_q     <= inv_q;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/node_info.sv
`timescale 1ns/10ps

module node_info (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            en_mni,
    input  logic                            i_am_dest,
    input  logic                            my_id_wr,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   my_id_data,
    input  wsn_pkg::pkt_type_e              pkt_type,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_src,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_value,
    output logic [wsn_pkg::NODE_ID_W-1:0]   my_id,
    output logic [wsn_pkg::NODE_ID_W-1:0]   hops_from_sink,
    output logic                            role_ch,    // 1 = this node is a ch
    output logic [7:0]                      timeslot
);

    logic [wsn_pkg::NODE_ID_W:0] hops_new;              // extra bit so 0xFFFF+1 loses

    assign hops_new = {1'b0, pkt_value} + 1'b1;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            my_id          <= '0;
            hops_from_sink <= '1;                       // unknown distance
            role_ch        <= 1'b0;
            timeslot       <= '0;
        end else begin
            if (my_id_wr)
                my_id <= my_id_data;
            if (en_mni) begin
                case (pkt_type)
                    wsn_pkg::PKT_HEARTBEAT: begin
                        if (hops_new < {1'b0, hops_from_sink})  // keep the shortest path
                            hops_from_sink <= hops_new[wsn_pkg::NODE_ID_W-1:0];
                    end
                    wsn_pkg::PKT_CHE:
                        role_ch <= (pkt_src == my_id);  // elected or demoted
                    wsn_pkg::PKT_CH_TIMESLOT: begin
                        if (i_am_dest)
                            timeslot <= pkt_value[7:0];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: source/pkt_apb_regs.sv
`timescale 1ns/10ps

module pkt_apb_regs #(
    parameter int NBR_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [wsn_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic [wsn_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [wsn_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic [wsn_pkg::NODE_ID_W-1:0]   pkt_src,
    output logic [wsn_pkg::NODE_ID_W-1:0]   pkt_dest,
    output logic [wsn_pkg::NODE_ID_W-1:0]   pkt_value,
    output wsn_pkg::pkt_type_e              pkt_type,
    output logic                            new_pkt,
    output logic                            my_id_wr,
    output logic                            clr_recluster,
    output logic [wsn_pkg::NODE_ID_W-1:0]   my_id_data,
    input  logic                            fwd,
    input  logic [31:0]                     node_status,
    input  logic [31:0]                     ch_info,
    output logic [$clog2(NBR_DEPTH)-1:0]    nbr_index,
    input  logic [wsn_pkg::NODE_ID_W:0]     nbr_entry
);

    localparam int IDX_W   = $clog2(NBR_DEPTH);
    localparam int NBR_END = int'(wsn_pkg::REG_NBR_BASE) + 4 * NBR_DEPTH;

    logic                               access;         // apb access phase
    logic                               wr_en;          // legal write this edge
    logic                               addr_ok;
    logic                               read_only;
    logic                               nbr_hit;
    logic                               cmd_wr;         // cmd write seen, one edge back
    logic [wsn_pkg::NODE_ID_W-1:0]      fwd_count;
    logic [wsn_pkg::APB_DATA_W-1:0]     rd_data;

    assign access    = psel & penable;
    assign wr_en     = access & pwrite & addr_ok & ~read_only;
    assign pready    = 1'b1;                            // zero wait states
    assign pslverr   = access & (~addr_ok | (pwrite & read_only));
    assign prdata    = (access && !pwrite) ? rd_data : '0;
    assign nbr_index = paddr[IDX_W+1:2];                // word index into the table
    assign nbr_hit   = (paddr >= wsn_pkg::REG_NBR_BASE) && (int'(paddr) < NBR_END) &&
                       (paddr[1:0] == 2'b00);
    assign clr_recluster = wr_en && (paddr == wsn_pkg::REG_CTRL) && pwdata[0];

    // address decode and read mux
    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (paddr)
            wsn_pkg::REG_SRC:         rd_data[wsn_pkg::NODE_ID_W-1:0] = pkt_src;
            wsn_pkg::REG_DEST:        rd_data[wsn_pkg::NODE_ID_W-1:0] = pkt_dest;
            wsn_pkg::REG_VALUE:       rd_data[wsn_pkg::NODE_ID_W-1:0] = pkt_value;
            wsn_pkg::REG_CMD:         rd_data[2:0] = pkt_type;
            wsn_pkg::REG_MY_ID:       rd_data[wsn_pkg::NODE_ID_W-1:0] = my_id_data;
            wsn_pkg::REG_CTRL:        rd_data = '0;     // write-only pulse, reads 0
            wsn_pkg::REG_NODE_STATUS: begin
                rd_data   = node_status;
                read_only = 1'b1;
            end
            wsn_pkg::REG_CH_INFO: begin
                rd_data   = ch_info;
                read_only = 1'b1;
            end
            wsn_pkg::REG_FWD_COUNT: begin
                rd_data[wsn_pkg::NODE_ID_W-1:0] = fwd_count;
                read_only = 1'b1;
            end
            default: begin
                if (nbr_hit) begin                      // neighbor window
                    rd_data[wsn_pkg::NODE_ID_W:0] = nbr_entry;
                    read_only = 1'b1;
                end else begin
                    addr_ok = 1'b0;                     // hole in the map
                end
            end
        endcase
    end

    // packet field registers, held until rewritten
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr)
                wsn_pkg::REG_SRC:   pkt_src   <= pwdata[wsn_pkg::NODE_ID_W-1:0];
                wsn_pkg::REG_DEST:  pkt_dest  <= pwdata[wsn_pkg::NODE_ID_W-1:0];
                wsn_pkg::REG_VALUE: pkt_value <= pwdata[wsn_pkg::NODE_ID_W-1:0];
                wsn_pkg::REG_CMD:   pkt_type  <= wsn_pkg::pkt_type_e'(pwdata[2:0]);
                default: ;
            endcase
        end
    end

    // control pulses, own id and forward counter
    always_ff @(posedge clk) begin
        if (!nrst) begin
            cmd_wr     <= 1'b0;
            new_pkt    <= 1'b0;
            my_id_wr   <= 1'b0;
            my_id_data <= '0;
            fwd_count  <= '0;
        end else begin
            cmd_wr   <= wr_en && (paddr == wsn_pkg::REG_CMD);
            new_pkt  <= cmd_wr;                         // one cycle, edge after access
            my_id_wr <= wr_en && (paddr == wsn_pkg::REG_MY_ID);
            if (wr_en && (paddr == wsn_pkg::REG_MY_ID))
                my_id_data <= pwdata[wsn_pkg::NODE_ID_W-1:0];
            if (fwd)
                fwd_count <= fwd_count + 1'b1;          // wraps at 16 bits
        end
    end

endmodule

// File: source/pkt_filter.sv
`timescale 1ns/10ps

module pkt_filter (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            new_pkt,
    input  wsn_pkg::pkt_type_e              pkt_type,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_dest,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   my_id,
    input  logic                            role_ch,
    output logic                            en_mni,     // node_info enable
    output logic                            en_kch,     // known_ch enable
    output logic                            en_qtu,     // q table enable
    output logic                            i_am_dest,
    output logic                            fwd         // node must forward
);

    logic dest_match;
    logic mni_d;
    logic kch_d;
    logic qtu_d;
    logic fwd_d;

    assign dest_match = (pkt_dest == my_id);

    // type decode, only meaningful with new_pkt
    always_comb begin
        mni_d = 1'b0;
        kch_d = 1'b0;
        qtu_d = 1'b0;
        fwd_d = 1'b0;
        case (pkt_type)
            wsn_pkg::PKT_HEARTBEAT: begin
                mni_d = 1'b1;
                fwd_d = 1'b1;                           // ripple toward the edge
            end
            wsn_pkg::PKT_CHE: begin
                mni_d = 1'b1;
                kch_d = 1'b1;
            end
            wsn_pkg::PKT_INVITE: begin
                kch_d = 1'b1;
                fwd_d = 1'b1;                           // pass invite to one-hop nbrs
            end
            wsn_pkg::PKT_MEMBER_REQ: qtu_d = 1'b1;
            wsn_pkg::PKT_CH_TIMESLOT: begin
                mni_d = 1'b1;
                fwd_d = role_ch;                        // only a ch sends timeslots on
            end
            wsn_pkg::PKT_DATA,
            wsn_pkg::PKT_SOS: begin
                qtu_d = 1'b1;
                fwd_d = dest_match;                     // relay only if addressed to us
            end
            default: ;                                  // code 7 unused
        endcase
    end

    // all outputs are single-cycle pulses
    always_ff @(posedge clk) begin
        if (!nrst) begin
            en_mni    <= 1'b0;
            en_kch    <= 1'b0;
            en_qtu    <= 1'b0;
            i_am_dest <= 1'b0;
            fwd       <= 1'b0;
        end else begin
            en_mni    <= new_pkt & mni_d;
            en_kch    <= new_pkt & kch_d;
            en_qtu    <= new_pkt & qtu_d;
            i_am_dest <= new_pkt & dest_match;
            fwd       <= new_pkt & fwd_d;
        end
    end

endmodule

// File: source/q_table_update.sv
`timescale 1ns/10ps

module q_table_update #(
    parameter int NBR_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            en_qtu,
    input  wsn_pkg::pkt_type_e              pkt_type,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_src,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_dest,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   pkt_value,
    input  logic                            ch_valid,
    input  logic [wsn_pkg::NODE_ID_W-1:0]   ch_id,
    input  logic                            clr_recluster,
    input  logic [$clog2(NBR_DEPTH)-1:0]    nbr_index,
    output logic [wsn_pkg::NODE_ID_W:0]     nbr_entry,  // {valid, q}
    output logic                            recluster
);

    localparam int IDX_W = $clog2(NBR_DEPTH);

    logic [wsn_pkg::NODE_ID_W-1:0]  nbr_q [NBR_DEPTH];
    logic [NBR_DEPTH-1:0]           nbr_valid;
    logic [IDX_W-1:0]               wr_idx;
    logic                           wr_en;
    logic                           join_req;           // member req to our ch

    assign wr_idx   = pkt_src[IDX_W-1:0];               // src modulo depth
    assign join_req = (pkt_type == wsn_pkg::PKT_MEMBER_REQ) && ch_valid && (pkt_dest == ch_id);
    assign wr_en    = en_qtu && (join_req ||
                      (((pkt_type == wsn_pkg::PKT_DATA) || (pkt_type == wsn_pkg::PKT_SOS)) &&
                       nbr_valid[wr_idx]));             // data only refreshes known nbrs

    // invalid entries read as zero
    assign nbr_entry = nbr_valid[nbr_index] ? {1'b1, nbr_q[nbr_index]} : '0;

    always_ff @(posedge clk) begin
        if (wr_en)
            nbr_q[wr_idx] <= pkt_value;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            nbr_valid <= '0;
            recluster <= 1'b0;
        end else begin
            if (wr_en)
                nbr_valid[wr_idx] <= 1'b1;
            if (en_qtu && (pkt_type == wsn_pkg::PKT_SOS))
                recluster <= 1'b1;                      // sticky until host clears
            else if (clr_recluster)
                recluster <= 1'b0;
        end
    end

endmodule

// File: source/wsn_pkg.sv
package wsn_pkg;

    localparam int NODE_ID_W  = 16;         // node ids and packet values
    localparam int APB_DATA_W = 32;
    localparam int APB_ADDR_W = 8;

    // packet type carried in the cmd register
    typedef enum logic [2:0] {
        PKT_HEARTBEAT   = 3'd0,             // hop distance flood from the sink
        PKT_CHE         = 3'd1,             // cluster head election
        PKT_INVITE      = 3'd2,             // ch invite, hops and q piggybacked
        PKT_MEMBER_REQ  = 3'd3,             // member asks to join a ch
        PKT_CH_TIMESLOT = 3'd4,             // ch hands out timeslots
        PKT_DATA        = 3'd5,
        PKT_SOS         = 3'd6              // data plus low energy warning
    } pkt_type_e;

    // apb byte addresses
    typedef enum logic [7:0] {
        REG_SRC         = 8'h00,
        REG_DEST        = 8'h04,
        REG_VALUE       = 8'h08,
        REG_CMD         = 8'h0C,            // write starts processing
        REG_MY_ID       = 8'h10,
        REG_NODE_STATUS = 8'h14,            // read only
        REG_CH_INFO     = 8'h18,            // read only
        REG_FWD_COUNT   = 8'h1C,            // read only
        REG_CTRL        = 8'h20,            // bit 0 clears recluster
        REG_NBR_BASE    = 8'h40             // neighbor i at base + 4*i
    } reg_addr_e;

endpackage

// File: verification/cluster_node_assertions.sv
`timescale 1ns/10ps

module cluster_node_assertions (
    input logic clk,
    input logic nrst,
    input logic new_pkt,
    input logic en_mni,
    input logic en_kch,
    input logic en_qtu,
    input logic i_am_dest,
    input logic fwd
);

    logic any_en;

    assign any_en = en_mni | en_kch | en_qtu | i_am_dest | fwd;

    // pulses only in the cycle after new_pkt
    quiet_without_pkt: assert property (@(posedge clk) disable iff (!nrst)
        !new_pkt |=> !any_en)
        else $error("filter output high without a preceding new_pkt");

    mni_qtu_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(en_mni && en_qtu))
        else $error("en_mni and en_qtu high together");

    new_pkt_single: assert property (@(posedge clk) disable iff (!nrst)
        new_pkt |=> !new_pkt)
        else $error("new_pkt held for two cycles");

endmodule

bind pkt_filter cluster_node_assertions u_filter_checks (
    .clk(clk), .nrst(nrst), .new_pkt(new_pkt),
    .en_mni(en_mni), .en_kch(en_kch), .en_qtu(en_qtu),
    .i_am_dest(i_am_dest), .fwd(fwd)
);

// File: verification/cluster_node_trace.txt
// columns: op addr data err (data is write data or expected read data, err is pslverr)
// op 1 = apb write, 2 = apb read and compare, 0 = end of trace
1 10 00000005 0
2 10 00000005 0
1 00 00000001 0
1 04 00000000 0
1 08 00000005 0
1 0c 00000000 0
1 08 00000002 0
1 0c 00000000 0
1 08 00000009 0
1 0c 00000000 0
2 14 00030000 0
2 1c 00000003 0
1 00 00000005 0
1 0c 00000001 0
2 14 00030001 0
1 04 00000005 0
1 08 00000022 0
1 0c 00000004 0
2 14 00032201 0
2 1c 00000004 0
1 00 00000011 0
1 08 00000a03 0
1 0c 00000002 0
2 18 110a0301 0
1 00 00000012 0
1 08 00003206 0
1 0c 00000002 0
2 18 110a0301 0
1 00 00000013 0
1 08 00001402 0
1 0c 00000002 0
2 18 13140201 0
2 1c 00000007 0
1 00 00000022 0
1 04 00000013 0
1 08 00001234 0
1 0c 00000003 0
2 48 00011234 0
1 00 00000023 0
1 04 00000099 0
1 08 00005555 0
1 0c 00000003 0
2 4c 00000000 0
1 00 00000022 0
1 04 00000005 0
1 08 00000777 0
1 0c 00000005 0
2 48 00010777 0
1 00 00000023 0
1 04 00000044 0
1 08 00000888 0
1 0c 00000005 0
2 4c 00000000 0
2 1c 00000008 0
1 00 00000022 0
1 08 00000999 0
1 0c 00000006 0
2 48 00010999 0
2 14 00032203 0
1 20 00000001 0
2 14 00032201 0
1 00 00000013 0
1 0c 00000001 0
2 14 00032200 0
2 18 13140200 0
2 30 00000000 1
1 1c 00000005 1
2 1c 00000008 0
0 00 00000000 0

// File: verification/tb_cluster_node.sv
`timescale 1ns/10ps

module tb_cluster_node;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_RECS   = 128;                // trace records
    localparam int PREADY_TMO = 16;                 // cycles per access

    logic                            clk;
    logic                            nrst;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [wsn_pkg::APB_ADDR_W-1:0]  paddr;
    logic [wsn_pkg::APB_DATA_W-1:0]  pwdata;
    logic [wsn_pkg::APB_DATA_W-1:0]  prdata;
    logic                            pready;
    logic                            pslverr;

    logic [31:0] trace_mem [4*MAX_RECS];            // op, addr, data, err per record

    cluster_node_top #(.NBR_DEPTH(8), .MAX_CH_HOPS(4)) u_dut (
        .clk(clk), .nrst(nrst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input logic [wsn_pkg::APB_DATA_W-1:0] got,
                              input logic [wsn_pkg::APB_DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // one apb transfer that starts 2 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [wsn_pkg::APB_ADDR_W-1:0] addr,
                            input logic [wsn_pkg::APB_DATA_W-1:0] wdata,
                            output logic [wsn_pkg::APB_DATA_W-1:0] rdata, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;                             // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2 penable = 1'b1;                          // access phase
        @(negedge clk);
        while (!pready && waits < PREADY_TMO) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            abort_run($sformatf("no pready within %0d cycles at address %h", PREADY_TMO, addr));
        end else begin
            rdata = prdata;                         // stable mid-cycle
            err   = pslverr;
            @(posedge clk);
            #2;
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    initial begin
        int                             rec;
        int                             gap;
        logic [31:0]                    op;
        logic [wsn_pkg::APB_ADDR_W-1:0] addr;
        logic [wsn_pkg::APB_DATA_W-1:0] data;
        logic [wsn_pkg::APB_DATA_W-1:0] rdata;
        logic                           err;
        logic                           done;
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        done    = 1'b0;
        rec     = 0;
        void'($urandom(32'ha89e_bd19));
        $readmemh("verification/cluster_node_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        #2 nrst = 1'b1;
        while (!done) begin
            if (rec >= MAX_RECS) begin
                abort_run("trace ran past its last record without an end record");
            end else begin
                op   = trace_mem[4*rec];
                addr = trace_mem[4*rec+1][wsn_pkg::APB_ADDR_W-1:0];
                data = trace_mem[4*rec+2];
                if (op == 32'd0) begin
                    done = 1'b1;
                end else if (op == 32'd1 || op == 32'd2) begin
                    @(posedge clk);
                    #2;
                    apb_xfer(op == 32'd1, addr, data, rdata, err);
                    check_err($sformatf("pslverr@%h", addr), err, trace_mem[4*rec+3][0]);
                    if (op == 32'd2)
                        check_data($sformatf("prdata@%h", addr), rdata, data);
                    if (op == 32'd1 && addr == wsn_pkg::REG_CMD) begin
                        gap = 4 + int'($urandom % 4);   // let the packet settle
                        repeat (gap) @(posedge clk);
                    end
                    rec++;
                end else begin
                    abort_run($sformatf("unknown operation in trace record %0d", rec));
                end
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule
